// File: src/nlc_pkg.sv
package nlc_pkg;

  // Channel bank
  localparam int NUM_CH = 4;
  localparam int CH_W = 2;

  // Sample and word widths
  localparam int SAMPLE_W = 21; // sign + 20-bit magnitude
  localparam int DATA_W = 32;
  localparam int NUM_FRAC = 8;  // 1.0 == 256
  localparam int MAG_MAX = (1 << (SAMPLE_W - 1)) - 1;

  // Polynomial
  localparam int POLY_ORDER = 5;
  localparam int ROUND_W = 3;   // Horner round counter
  localparam int NUM_COEF = 8;  // words per channel in the bank

  typedef enum logic [2:0] {
    COEF_NEG_MEAN = 3'd0,
    COEF_RECIP    = 3'd1,
    COEF_C0       = 3'd2,
    COEF_C1       = 3'd3,
    COEF_C2       = 3'd4,
    COEF_C3       = 3'd5,
    COEF_C4       = 3'd6,
    COEF_C5       = 3'd7
  } coef_sel_t;

  // OP_NORM   : ((a + b) * c) >>> NUM_FRAC
  // OP_HORNER : ((a * b) >>> NUM_FRAC) + c
  typedef enum logic {
    OP_NORM   = 1'b0,
    OP_HORNER = 1'b1
  } arith_op_t;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_NORM   = 2'd1,
    ST_HORNER = 2'd2,
    ST_DONE   = 2'd3
  } seq_state_t;

endpackage

// File: src/nlc_coef_bank.sv
`timescale 1ns/1ps

module nlc_coef_bank (
  input  logic                           clk,
  input  logic                           rst,
  // Host write port
  input  logic                           coef_we,
  input  logic [nlc_pkg::CH_W-1:0]       coef_ch,
  input  nlc_pkg::coef_sel_t             coef_sel,
  input  logic [nlc_pkg::DATA_W-1:0]     coef_wdata,
  // Sequencer read port, two words of one channel
  input  logic [nlc_pkg::CH_W-1:0]       rd_ch,
  input  nlc_pkg::coef_sel_t             rd_sel_a,
  input  nlc_pkg::coef_sel_t             rd_sel_b,
  output logic [nlc_pkg::DATA_W-1:0]     rd_data_a,
  output logic [nlc_pkg::DATA_W-1:0]     rd_data_b
);

  logic [nlc_pkg::DATA_W-1:0] mem [nlc_pkg::NUM_CH][nlc_pkg::NUM_COEF];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < nlc_pkg::NUM_CH; c++) begin
        for (int s = 0; s < nlc_pkg::NUM_COEF; s++) begin
          mem[c][s] <= '0;
        end
      end
    end else if (coef_we) begin
      mem[coef_ch][coef_sel] <= coef_wdata;
    end
  end

  // Combinational reads, used in the issue cycle
  assign rd_data_a = mem[rd_ch][rd_sel_a];
  assign rd_data_b = mem[rd_ch][rd_sel_b];

endmodule

// File: src/nlc_arith_pipe.sv
`timescale 1ns/1ps

module nlc_arith_pipe (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              issue_valid,
  input  nlc_pkg::arith_op_t                issue_op,
  input  logic [nlc_pkg::CH_W-1:0]          issue_ch,
  input  logic signed [nlc_pkg::DATA_W-1:0] op_a,
  input  logic signed [nlc_pkg::DATA_W-1:0] op_b,
  input  logic signed [nlc_pkg::DATA_W-1:0] op_c,
  output logic                              res_valid,
  output logic [nlc_pkg::CH_W-1:0]          res_ch,
  output logic signed [nlc_pkg::DATA_W-1:0] res_data
);

  logic signed [nlc_pkg::DATA_W-1:0]   pre_sum;
  logic signed [nlc_pkg::DATA_W-1:0]   mul_x;
  logic signed [nlc_pkg::DATA_W-1:0]   mul_y;
  logic signed [2*nlc_pkg::DATA_W-1:0] product;

  logic                                s1_valid;
  nlc_pkg::arith_op_t                  s1_op;
  logic [nlc_pkg::CH_W-1:0]            s1_ch;
  logic signed [nlc_pkg::DATA_W-1:0]   s1_addend;
  logic signed [2*nlc_pkg::DATA_W-1:0] s1_prod;

  logic signed [2*nlc_pkg::DATA_W-1:0] prod_sh;
  logic signed [nlc_pkg::DATA_W-1:0]   stage2_word;

  // Stage 1 operand select
  assign pre_sum = op_a + op_b; // wraps at DATA_W
  assign mul_x   = (issue_op == nlc_pkg::OP_NORM) ? pre_sum : op_a;
  assign mul_y   = (issue_op == nlc_pkg::OP_NORM) ? op_c : op_b;
  assign product = mul_x * mul_y; // full 64-bit signed product

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid;
      res_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_op     <= issue_op;
    s1_ch     <= issue_ch;
    s1_addend <= op_c;       // Horner constant
    s1_prod   <= product;
    res_ch    <= s1_ch;
    res_data  <= stage2_word;
  end

  // Stage 2 rescales, truncates and adds the constant
  assign prod_sh = s1_prod >>> nlc_pkg::NUM_FRAC;

  always_comb begin
    stage2_word = prod_sh[nlc_pkg::DATA_W-1:0];
    if (s1_op == nlc_pkg::OP_HORNER) begin
      stage2_word = stage2_word + s1_addend;
    end
  end

endmodule

// File: src/nlc_sequencer.sv
`timescale 1ns/1ps

module nlc_sequencer (
  input  logic                                          clk,
  input  logic                                          rst,
  // Frame handshake
  input  logic                                          req,
  input  logic [nlc_pkg::NUM_CH*nlc_pkg::SAMPLE_W-1:0]  x_adc,
  output logic                                          ack,
  // Coefficient bank reads
  output logic [nlc_pkg::CH_W-1:0]                      rd_ch,
  output nlc_pkg::coef_sel_t                            rd_sel_a,
  output nlc_pkg::coef_sel_t                            rd_sel_b,
  input  logic signed [nlc_pkg::DATA_W-1:0]             rd_data_a,
  input  logic signed [nlc_pkg::DATA_W-1:0]             rd_data_b,
  // Pipeline issue
  output logic                                          issue_valid,
  output nlc_pkg::arith_op_t                            issue_op,
  output logic [nlc_pkg::CH_W-1:0]                      issue_ch,
  output logic signed [nlc_pkg::DATA_W-1:0]             op_a,
  output logic signed [nlc_pkg::DATA_W-1:0]             op_b,
  output logic signed [nlc_pkg::DATA_W-1:0]             op_c,
  // Pipeline return
  input  logic                                          res_valid,
  input  logic [nlc_pkg::CH_W-1:0]                      res_ch,
  input  logic signed [nlc_pkg::DATA_W-1:0]             res_data,
  // Formatter
  output logic                                          load_out,
  output logic [nlc_pkg::NUM_CH*nlc_pkg::DATA_W-1:0]    acc_flat
);

  nlc_pkg::seq_state_t                             state;
  logic [nlc_pkg::CH_W-1:0]                        ch_cnt;
  logic [nlc_pkg::ROUND_W-1:0]                     round_cnt;
  logic                                            issue_done;  // all ops of frame issued
  logic [nlc_pkg::NUM_CH-1:0]                      busy;        // result outstanding
  logic [nlc_pkg::NUM_CH-1:0]                      xn_valid;    // normalize result seen

  logic signed [nlc_pkg::DATA_W-1:0]               x_conv [nlc_pkg::NUM_CH];
  logic signed [nlc_pkg::DATA_W-1:0]               x_q    [nlc_pkg::NUM_CH];
  logic signed [nlc_pkg::DATA_W-1:0]               xn     [nlc_pkg::NUM_CH];
  logic [nlc_pkg::NUM_CH-1:0][nlc_pkg::DATA_W-1:0] acc;

  logic                                            fwd;
  logic signed [nlc_pkg::DATA_W-1:0]               xn_cur;
  logic signed [nlc_pkg::DATA_W-1:0]               acc_cur;

  // Sign-magnitude to two's complement in Q format
  always_comb begin
    for (int i = 0; i < nlc_pkg::NUM_CH; i++) begin
      x_conv[i] = nlc_pkg::DATA_W'(x_adc[i*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W-1])
                  << nlc_pkg::NUM_FRAC;
      if (x_adc[(i+1)*nlc_pkg::SAMPLE_W-1]) begin
        x_conv[i] = -x_conv[i];
      end
    end
  end

  // Result landing this cycle for the channel being issued
  assign fwd     = res_valid && (res_ch == ch_cnt);
  assign xn_cur  = (fwd && !xn_valid[ch_cnt]) ? res_data : xn[ch_cnt];
  assign acc_cur = fwd ? res_data : acc[ch_cnt];

  always_comb begin
    rd_ch       = ch_cnt;
    issue_ch    = ch_cnt;
    issue_valid = 1'b0;
    issue_op    = nlc_pkg::OP_NORM;
    rd_sel_a    = nlc_pkg::COEF_NEG_MEAN;
    rd_sel_b    = nlc_pkg::COEF_RECIP;
    op_a        = x_q[ch_cnt];
    op_b        = rd_data_a;
    op_c        = rd_data_b;
    if (state == nlc_pkg::ST_HORNER) begin
      issue_op = nlc_pkg::OP_HORNER;
      rd_sel_a = nlc_pkg::COEF_C5;
      rd_sel_b = nlc_pkg::coef_sel_t'(nlc_pkg::COEF_C4 - round_cnt); // C4 down to C0
      op_a     = (round_cnt == '0) ? rd_data_a : acc_cur;
      op_b     = xn_cur;
    end
    if ((state == nlc_pkg::ST_NORM) || (state == nlc_pkg::ST_HORNER && !issue_done)) begin
      issue_valid = !busy[ch_cnt] || fwd;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= nlc_pkg::ST_IDLE;
      ch_cnt     <= '0;
      round_cnt  <= '0;
      issue_done <= 1'b0;
      busy       <= '0;
      xn_valid   <= '0;
      ack        <= 1'b0;
      load_out   <= 1'b0;
    end else begin
      load_out <= 1'b0;
      if (res_valid) begin
        busy[res_ch]     <= 1'b0;
        xn_valid[res_ch] <= 1'b1;
      end
      if (issue_valid) busy[ch_cnt] <= 1'b1;

      case (state)
        nlc_pkg::ST_IDLE: begin
          if (req) begin
            ch_cnt     <= '0;
            round_cnt  <= '0;
            issue_done <= 1'b0;
            xn_valid   <= '0;
            state      <= nlc_pkg::ST_NORM;
          end
        end
        nlc_pkg::ST_NORM, nlc_pkg::ST_HORNER: begin
          if (issue_valid) begin
            if (ch_cnt == nlc_pkg::CH_W'(nlc_pkg::NUM_CH - 1)) begin
              ch_cnt <= '0;
              if (state == nlc_pkg::ST_NORM) begin
                state <= nlc_pkg::ST_HORNER;
              end else if (round_cnt == nlc_pkg::ROUND_W'(nlc_pkg::POLY_ORDER - 1)) begin
                issue_done <= 1'b1;
              end else begin
                round_cnt <= round_cnt + 1'b1;
              end
            end else begin
              ch_cnt <= ch_cnt + 1'b1;
            end
          end
          // Last channel of last round coming back
          if (issue_done && res_valid && res_ch == nlc_pkg::CH_W'(nlc_pkg::NUM_CH - 1)) begin
            load_out <= 1'b1;
            state    <= nlc_pkg::ST_DONE;
          end
        end
        nlc_pkg::ST_DONE: begin
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= nlc_pkg::ST_IDLE;
          end
        end
        default: state <= nlc_pkg::ST_IDLE;
      endcase
    end
  end

  // Per-channel datapath registers
  always_ff @(posedge clk) begin
    if (state == nlc_pkg::ST_IDLE && req) begin
      for (int i = 0; i < nlc_pkg::NUM_CH; i++) begin
        x_q[i] <= x_conv[i];
      end
    end
    if (res_valid) begin
      if (xn_valid[res_ch]) acc[res_ch] <= res_data; // Horner step
      else xn[res_ch] <= res_data;                     // normalized sample
    end
  end

  assign acc_flat = acc;

endmodule

// File: src/nlc_output_fmt.sv
`timescale 1ns/1ps

module nlc_output_fmt (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          load_out,
  input  logic [nlc_pkg::NUM_CH*nlc_pkg::DATA_W-1:0]    acc_flat,
  output logic [nlc_pkg::NUM_CH*nlc_pkg::SAMPLE_W-1:0]  x_lin
);

  logic signed [nlc_pkg::DATA_W-1:0]            shifted [nlc_pkg::NUM_CH];
  logic [nlc_pkg::DATA_W-1:0]                   mag     [nlc_pkg::NUM_CH];
  logic [nlc_pkg::NUM_CH*nlc_pkg::SAMPLE_W-1:0] x_fmt;

  always_comb begin
    for (int i = 0; i < nlc_pkg::NUM_CH; i++) begin
      shifted[i] = $signed(acc_flat[i*nlc_pkg::DATA_W +: nlc_pkg::DATA_W]) >>> nlc_pkg::NUM_FRAC;
      mag[i]     = shifted[i][nlc_pkg::DATA_W-1] ? -shifted[i] : shifted[i];
      if (mag[i] > nlc_pkg::DATA_W'(nlc_pkg::MAG_MAX)) begin
        mag[i] = nlc_pkg::DATA_W'(nlc_pkg::MAG_MAX); // saturate
      end
      // Negative values never reach zero magnitude, so zero stays positive
      x_fmt[i*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W] =
        {shifted[i][nlc_pkg::DATA_W-1], mag[i][nlc_pkg::SAMPLE_W-2:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_lin <= '0;
    end else if (load_out) begin
      x_lin <= x_fmt;
    end
  end

endmodule

// File: src/nlc_top.sv
`timescale 1ns/1ps

module nlc_top (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          coef_we,
  input  logic [nlc_pkg::CH_W-1:0]                      coef_ch,
  input  nlc_pkg::coef_sel_t                            coef_sel,
  input  logic [nlc_pkg::DATA_W-1:0]                    coef_wdata,
  input  logic                                          req,
  input  logic [nlc_pkg::NUM_CH*nlc_pkg::SAMPLE_W-1:0]  x_adc,
  output logic                                          ack,
  output logic [nlc_pkg::NUM_CH*nlc_pkg::SAMPLE_W-1:0]  x_lin
);

  logic [nlc_pkg::CH_W-1:0]                     rd_ch;
  nlc_pkg::coef_sel_t                           rd_sel_a;
  nlc_pkg::coef_sel_t                           rd_sel_b;
  logic [nlc_pkg::DATA_W-1:0]                   rd_data_a;
  logic [nlc_pkg::DATA_W-1:0]                   rd_data_b;

  logic                                         issue_valid;
  nlc_pkg::arith_op_t                           issue_op;
  logic [nlc_pkg::CH_W-1:0]                     issue_ch;
  logic signed [nlc_pkg::DATA_W-1:0]            op_a;
  logic signed [nlc_pkg::DATA_W-1:0]            op_b;
  logic signed [nlc_pkg::DATA_W-1:0]            op_c;

  logic                                         res_valid;
  logic [nlc_pkg::CH_W-1:0]                     res_ch;
  logic signed [nlc_pkg::DATA_W-1:0]            res_data;

  logic                                         load_out;
  logic [nlc_pkg::NUM_CH*nlc_pkg::DATA_W-1:0]   acc_flat;

  nlc_coef_bank u_coef_bank (
    .clk        (clk),
    .rst        (rst),
    .coef_we    (coef_we),
    .coef_ch    (coef_ch),
    .coef_sel   (coef_sel),
    .coef_wdata (coef_wdata),
    .rd_ch      (rd_ch),
    .rd_sel_a   (rd_sel_a),
    .rd_sel_b   (rd_sel_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b)
  );

  nlc_sequencer u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .x_adc       (x_adc),
    .ack         (ack),
    .rd_ch       (rd_ch),
    .rd_sel_a    (rd_sel_a),
    .rd_sel_b    (rd_sel_b),
    .rd_data_a   (rd_data_a),
    .rd_data_b   (rd_data_b),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_ch    (issue_ch),
    .op_a        (op_a),
    .op_b        (op_b),
    .op_c        (op_c),
    .res_valid   (res_valid),
    .res_ch      (res_ch),
    .res_data    (res_data),
    .load_out    (load_out),
    .acc_flat    (acc_flat)
  );

  nlc_arith_pipe u_arith_pipe (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_ch    (issue_ch),
    .op_a        (op_a),
    .op_b        (op_b),
    .op_c        (op_c),
    .res_valid   (res_valid),
    .res_ch      (res_ch),
    .res_data    (res_data)
  );

  nlc_output_fmt u_output_fmt (
    .clk      (clk),
    .rst      (rst),
    .load_out (load_out),
    .acc_flat (acc_flat),
    .x_lin    (x_lin)
  );

endmodule

// File: dv/nlc_tb.sv
`timescale 1ns/1ps

module nlc_tb;

  typedef logic [nlc_pkg::NUM_CH*nlc_pkg::SAMPLE_W-1:0] frame_t;

  localparam int NUM_FRAMES = 28; // 4 identity, 20 random, 2 saturation, 2 handshake
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 64 + 200;

  logic                             clk;
  logic                             rst;
  logic                             coef_we;
  logic [nlc_pkg::CH_W-1:0]         coef_ch;
  nlc_pkg::coef_sel_t               coef_sel;
  logic [nlc_pkg::DATA_W-1:0]       coef_wdata;
  logic                             req;
  frame_t                           x_adc;
  logic                             ack;
  frame_t                           x_lin;

  logic [31:0] lfsr_state;
  int          coef_m [nlc_pkg::NUM_CH][nlc_pkg::NUM_COEF]; // host copy of the bank
  int          checks;
  int          errors;
  int          err_base;
  int          cycle_cnt;

  nlc_top uut (
    .clk        (clk),
    .rst        (rst),
    .coef_we    (coef_we),
    .coef_ch    (coef_ch),
    .coef_sel   (coef_sel),
    .coef_wdata (coef_wdata),
    .req        (req),
    .x_adc      (x_adc),
    .ack        (ack),
    .x_lin      (x_lin)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'hA3000000; // Galois feedback
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic int rand_signed(int n);
    int v;
    v = int'(rand_bits(n) << (32 - n));
    return v >>> (32 - n); // sign-extend from bit n-1
  endfunction

  function automatic logic [nlc_pkg::SAMPLE_W-1:0] random_sample(int mag_bits);
    logic        sgn;
    logic [31:0] m;
    sgn = lfsr_bit();
    m = rand_bits(mag_bits);
    return {sgn, m[nlc_pkg::SAMPLE_W-2:0]};
  endfunction

  function automatic frame_t random_frame(int mag_bits);
    frame_t f;
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      f[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W] = random_sample(mag_bits);
    end
    return f;
  endfunction

  // Smaller ranges for the higher-order terms
  function automatic int random_coef(int sel);
    case (sel)
      nlc_pkg::COEF_NEG_MEAN: return rand_signed(10);
      nlc_pkg::COEF_RECIP:    return int'(rand_bits(4));
      nlc_pkg::COEF_C5,
      nlc_pkg::COEF_C4:       return rand_signed(4);
      nlc_pkg::COEF_C3,
      nlc_pkg::COEF_C2:       return rand_signed(8);
      default:                return rand_signed(12);
    endcase
  endfunction

  // Reference model of normalize, Horner C5..C0, rescale and clamp
  function automatic logic [nlc_pkg::SAMPLE_W-1:0] model_channel(
    int ch, logic [nlc_pkg::SAMPLE_W-1:0] s);
    int     xq;
    int     sum;
    int     xn;
    int     acc;
    int     sh;
    longint mag;
    xq = int'(s[nlc_pkg::SAMPLE_W-2:0]) * (1 << nlc_pkg::NUM_FRAC);
    if (s[nlc_pkg::SAMPLE_W-1]) xq = -xq;
    sum = xq + coef_m[ch][nlc_pkg::COEF_NEG_MEAN];
    xn = int'((longint'(sum) * longint'(coef_m[ch][nlc_pkg::COEF_RECIP])) >>> nlc_pkg::NUM_FRAC);
    acc = coef_m[ch][nlc_pkg::COEF_C5];
    for (int k = nlc_pkg::COEF_C4; k >= nlc_pkg::COEF_C0; k--) begin
      acc = int'((longint'(acc) * longint'(xn)) >>> nlc_pkg::NUM_FRAC) + coef_m[ch][k];
    end
    sh = acc >>> nlc_pkg::NUM_FRAC;
    mag = (sh < 0) ? -longint'(sh) : longint'(sh);
    if (mag > nlc_pkg::MAG_MAX) mag = nlc_pkg::MAG_MAX;
    return {sh < 0, mag[nlc_pkg::SAMPLE_W-2:0]};
  endfunction

  task automatic check_value(input string name, input logic [127:0] act,
                             input logic [127:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
    end
  endtask

  task automatic write_coef(input int ch, input int sel, input int data);
    @(negedge clk);
    coef_we    = 1'b1;
    coef_ch    = nlc_pkg::CH_W'(ch);
    coef_sel   = nlc_pkg::coef_sel_t'(sel);
    coef_wdata = data;
    coef_m[ch][sel] = data;
  endtask

  task automatic load_random_coefs();
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      for (int sel = 0; sel < nlc_pkg::NUM_COEF; sel++) begin
        write_coef(ch, sel, random_coef(sel));
      end
    end
  endtask

  // Full four-phase exchange with ack held high for hold cycles
  task automatic run_frame(input frame_t samples, input int hold, output frame_t result);
    @(negedge clk);
    coef_we = 1'b0;
    x_adc   = samples;
    req     = 1'b1;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    result = x_lin;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value("ack", ack, 1'b1);
      check_value("x_lin", x_lin, result);
    end
    req = 1'b0;
    @(negedge clk);
    while (ack !== 1'b0) @(negedge clk);
    check_value("x_lin", x_lin, result); // held after ack drops
  endtask

  task automatic check_frame(input frame_t samples, input frame_t result);
    logic [nlc_pkg::SAMPLE_W-1:0] s;
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      s = samples[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W];
      check_value($sformatf("x_lin[%0d]", ch),
                  result[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W], model_channel(ch, s));
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == err_base) $display("%s: ok", name);
    else $display("%s: failed with %0d errors", name, errors - err_base);
    err_base = errors;
  endtask

  initial begin : main
    frame_t                       samples;
    frame_t                       result;
    frame_t                       prev;
    logic [nlc_pkg::SAMPLE_W-1:0] s;
    logic [nlc_pkg::SAMPLE_W-1:0] exp;
    logic                         sgn;
    int                           c0;
    int                           sel_ch;
    int                           hold;

    lfsr_state = 32'd56;
    checks     = 0;
    errors     = 0;
    err_base   = 0;
    rst        = 1'b1;
    coef_we    = 1'b0;
    coef_ch    = '0;
    coef_sel   = nlc_pkg::COEF_NEG_MEAN;
    coef_wdata = '0;
    req        = 1'b0;
    x_adc      = '0;
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      for (int sel = 0; sel < nlc_pkg::NUM_COEF; sel++) coef_m[ch][sel] = 0;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    check_value("ack", ack, 1'b0);
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      check_value($sformatf("x_lin[%0d]", ch),
                  x_lin[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W], '0);
    end
    finish_test("reset values");

    // Pass-through setup with xn = x and acc = C1 * xn
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      for (int sel = 0; sel < nlc_pkg::NUM_COEF; sel++) begin
        if (sel == nlc_pkg::COEF_RECIP || sel == nlc_pkg::COEF_C1) write_coef(ch, sel, 256);
        else write_coef(ch, sel, 0);
      end
    end
    for (int f = 0; f < 4; f++) begin
      samples = random_frame(20);
      if (f == 0) samples[nlc_pkg::SAMPLE_W-1:0] = 21'h100000; // negative zero
      run_frame(samples, 0, result);
      for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
        s = samples[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W];
        exp = (s[nlc_pkg::SAMPLE_W-2:0] == '0) ? '0 : s;
        check_value($sformatf("x_lin[%0d]", ch),
                    result[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W], exp);
      end
    end
    finish_test("identity");

    for (int f = 0; f < 20; f++) begin
      load_random_coefs();
      samples = random_frame(8);
      run_frame(samples, 0, result);
      check_frame(samples, result);
    end
    finish_test("random coefficients");

    for (int f = 0; f < 2; f++) begin
      for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
        sgn = ((ch % 2) == 1) ^ (f == 1);
        c0 = (1 << 28) + int'(rand_bits(20)); // well past MAG_MAX after rescale
        if (sgn) c0 = -c0;
        for (int sel = 0; sel < nlc_pkg::NUM_COEF; sel++) begin
          write_coef(ch, sel, (sel == nlc_pkg::COEF_C0) ? c0 : 0);
        end
      end
      samples = random_frame(20);
      run_frame(samples, 0, result);
      for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
        sgn = ((ch % 2) == 1) ^ (f == 1);
        exp = {sgn, nlc_pkg::MAG_MAX[nlc_pkg::SAMPLE_W-2:0]};
        check_value($sformatf("x_lin[%0d]", ch),
                    result[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W], exp);
      end
    end
    finish_test("saturation");

    load_random_coefs();
    samples = random_frame(8);
    hold = 1 + int'(rand_bits(4));
    run_frame(samples, hold, prev);
    check_frame(samples, prev);
    sel_ch = int'(rand_bits(nlc_pkg::CH_W));
    write_coef(sel_ch, nlc_pkg::COEF_C0,
               coef_m[sel_ch][nlc_pkg::COEF_C0] + 256 * (1 + int'(rand_bits(4))));
    hold = 1 + int'(rand_bits(4));
    run_frame(samples, hold, result);
    check_frame(samples, result);
    for (int ch = 0; ch < nlc_pkg::NUM_CH; ch++) begin
      if (ch != sel_ch) begin
        check_value($sformatf("x_lin[%0d]", ch),
                    result[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W],
                    prev[ch*nlc_pkg::SAMPLE_W +: nlc_pkg::SAMPLE_W]);
      end
    end
    finish_test("handshake and rewrite");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
src/nlc_pkg.sv
src/nlc_coef_bank.sv
src/nlc_arith_pipe.sv
src/nlc_sequencer.sv
src/nlc_output_fmt.sv
src/nlc_top.sv
dv/nlc_tb.sv
